// File: Makefile
# Verilator build and run of the command decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_pkt_decode
FILELIST  ?= pkt_decode.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Finished with no errors
FAIL_MSG  := Finished with errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qxF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qxF "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_pkt_decode.sv
// Testbench for the command decoder, sends host messages and checks replies and IO pins
`default_nettype none
`timescale 1ns/10ps

`include "pkt_decode_macros.svh"

module tb_pkt_decode;

   localparam int CLK_PERIOD   = 20;
   localparam int RST_CYCLES   = 8;
   localparam int N_TESTS      = 17;
   localparam int WATCH_CYCLES = N_TESTS * 60 + RST_CYCLES;

   // Field codes of the host protocol
   localparam logic [15:0] W_HEAD      = "ST";
   localparam logic [15:0] T_HS        = "00";
   localparam logic [15:0] T_IO        = "02";
   localparam logic [15:0] M_SET       = "01";
   localparam logic [15:0] M_EXE       = "02";
   localparam logic [15:0] M_SEX       = "03";
   localparam logic [15:0] M_RTN       = "04";
   localparam logic [15:0] W_PASS      = "PA";
   localparam logic [15:0] W_FAIL      = "FA";
   localparam logic [15:0] RX_END_WORD = {8'h0D, 8'h0A};
   localparam logic [15:0] TX_END_WORD = {8'h0A, 8'h0D};

   typedef struct packed {
      logic [15:0] pf;
      logic [15:0] code;
      logic        do_set;
      logic        do_exe;
      logic [7:0]  mask;
      logic [7:0]  dir;
      logic [7:0]  data;
   } outcome_t;

   logic                               clk;
   logic                               i_rst_n;
   logic                               i_rx_vd;
   logic [`PKT_WORD_NBIT-1:0]          i_rx_data;
   logic                               i_rx_sop;
   logic                               i_rx_eop;
   logic [`PKT_IO_NBIT-1:0]            i_io_db;
   logic [`PKT_IO_NBIT-1:0]            o_io_dir;
   logic [`PKT_IO_NBIT-1:0]            o_io_db;
   logic [`PKT_BANK_NBIT-1:0]          o_io_bank;
   logic                               o_tx_vd;
   logic [`PKT_BUF_ADDR_NBIT:0]        o_tx_addr;
   logic [`PKT_WORD_NBIT-1:0]          o_tx_data;
   logic                               o_tx_eop;

   // Model of the stored settings and the pins
   logic [7:0] st_mask;
   logic [7:0] st_dir;
   logic [7:0] st_data;
   logic [7:0] pin_dir;
   logic [7:0] pin_db;
   logic [7:0] pin_bank;

   // Reply words as {address, data}
   logic [`PKT_BUF_ADDR_NBIT+`PKT_WORD_NBIT:0] exp_q[$];
   logic [`PKT_BUF_ADDR_NBIT+`PKT_WORD_NBIT:0] got_q[$];

   // Handshake ends with its last word, IO replies one cycle after it
   logic exp_eop_vd;

   int err_cnt;
   int fail_tests;
   int done_cnt;
   int test_num;

   pkt_decode_top i_dut (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_rx_vd   (i_rx_vd),
      .i_rx_data (i_rx_data),
      .i_rx_sop  (i_rx_sop),
      .i_rx_eop  (i_rx_eop),
      .i_io_db   (i_io_db),
      .o_io_dir  (o_io_dir),
      .o_io_db   (o_io_db),
      .o_io_bank (o_io_bank),
      .o_tx_vd   (o_tx_vd),
      .o_tx_addr (o_tx_addr),
      .o_tx_data (o_tx_data),
      .o_tx_eop  (o_tx_eop)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic logic [7:0] hex_digit(input logic [3:0] n);
      if (n < 4'd10) begin
         return "0" + {4'h0, n};
      end
      return "A" + {4'h0, n} - 8'd10;
   endfunction

   function automatic logic [15:0] hex_word(input logic [7:0] b);
      return {hex_digit(b[7:4]), hex_digit(b[3:0])};
   endfunction

   // Code table and per-bit merge over the mask, direction and data payload
   function automatic outcome_t ref_outcome(input logic [15:0] mtype, input logic [15:0] mmode,
                                            input int n_data, input logic bad,
                                            input logic [23:0] payload,
                                            input logic [7:0] db_pins,
                                            input logic [7:0] cur_mask,
                                            input logic [7:0] cur_dir,
                                            input logic [7:0] cur_data);
      outcome_t   r;
      logic [7:0] m_mask;
      logic [7:0] m_dir;
      logic [7:0] m_data;
      int         i;
      m_mask   = payload[23:16];
      m_dir    = payload[15:8];
      m_data   = payload[7:0];
      r.pf     = W_FAIL;
      r.code   = "00";
      r.do_set = 1'b0;
      r.do_exe = 1'b0;
      r.mask   = cur_mask;
      r.dir    = cur_dir;
      r.data   = cur_data;
      if (mtype == T_HS) begin
         r.pf   = W_PASS;
         r.code = "01";
      end else if (mmode == M_SET || mmode == M_SEX) begin
         if (n_data != 3) begin
            r.code = (mmode == M_SET) ? "02" : "22";
         end else if (bad) begin
            r.code = (mmode == M_SET) ? "03" : "23";
         end else begin
            r.pf     = W_PASS;
            r.code   = (mmode == M_SET) ? "01" : "21";
            r.do_set = 1'b1;
            r.do_exe = (mmode == M_SEX);
         end
      end else if (mmode == M_EXE) begin
         if (n_data == 0) begin
            r.pf     = W_PASS;
            r.code   = "11";
            r.do_exe = 1'b1;
         end else begin
            r.code = "12";
         end
      end else if (mmode == M_RTN) begin
         r.pf   = bad ? W_FAIL : W_PASS;
         r.code = bad ? "23" : "21";
      end
      if (r.do_set) begin
         r.mask = m_mask;
         for (i = 0; i < 8; i++) begin
            if (!m_mask[i]) begin
               r.dir[i]  = m_dir[i];
               r.data[i] = m_dir[i] ? m_data[i] : db_pins[i];
            end
         end
      end
      return r;
   endfunction

   function automatic logic [15:0] ref_word(input int idx, input logic [7:0] chan,
                                            input logic [15:0] mtype, input outcome_t r);
      case (idx)
         0:       return W_HEAD;
         1:       return mtype;
         2:       return r.pf;
         3:       return r.code;
         4:       return hex_word(chan);
         5:       return hex_word(r.mask);
         6:       return hex_word(r.dir);
         7:       return hex_word(r.data);
         8:       return TX_END_WORD;
         default: return '0;
      endcase
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic check_pins();
      assert (o_io_dir == pin_dir && o_io_db == pin_db && o_io_bank == pin_bank) else begin
         err_cnt++;
         $display("ERR %0t: pins dir %h db %h bank %h, expected dir %h db %h bank %h",
                  $time, o_io_dir, o_io_db, o_io_bank, pin_dir, pin_db, pin_bank);
      end
   endtask

   task automatic check_reply(input logic eop_vd);
      int k;
      assert (eop_vd == exp_eop_vd) else begin
         err_cnt++;
         $display("ERR %0t: end pulse with valid %b, expected valid %b",
                  $time, eop_vd, exp_eop_vd);
      end
      assert (got_q.size() == exp_q.size()) else begin
         err_cnt++;
         $display("ERR %0t: reply has %0d words, expected %0d",
                  $time, got_q.size(), exp_q.size());
      end
      for (k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
         assert (got_q[k] == exp_q[k]) else begin
            err_cnt++;
            $display("ERR %0t: reply word %0d addr %h data %h, expected addr %h data %h",
                     $time, k, got_q[k][20:16], got_q[k][15:0],
                     exp_q[k][20:16], exp_q[k][15:0]);
         end
      end
      got_q.delete();
   endtask

   // Collects each reply up to its end pulse
   initial begin : compare_replies
      forever begin
         @(negedge clk);
         if (i_rst_n && o_tx_vd) begin
            got_q.push_back({o_tx_addr, o_tx_data});
         end
         if (i_rst_n && o_tx_eop) begin
            check_reply(o_tx_vd);
            done_cnt++;
         end
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   task automatic run_test(input string name, input logic [15:0] mtype,
                           input logic [15:0] mmode, input logic has_mode,
                           input logic [7:0] chan, input logic has_chan,
                           input int n_data, input logic [31:0] dbytes, input logic bad);
      outcome_t    r;
      logic [7:0]  db_val;
      logic [15:0] w;
      int          err_start;
      int          n_words;
      int          k;
      err_start = err_cnt;
      db_val    = 8'($urandom);
      r = ref_outcome(mtype, mmode, n_data, bad, dbytes[31:8], db_val,
                      st_mask, st_dir, st_data);
      st_mask = r.mask;
      st_dir  = r.dir;
      st_data = r.data;
      // Without a set the outcome carries the stored settings
      if (r.do_exe) begin
         pin_dir  = r.dir;
         pin_db   = r.data;
         pin_bank = chan;
      end
      n_words    = (mtype == T_HS) ? 4 : 16;
      exp_eop_vd = (mtype == T_HS);
      exp_q.delete();
      for (k = 0; k < n_words; k++) begin
         exp_q.push_back({mtype == T_IO, 4'(k), ref_word(k, chan, mtype, r)});
      end

      @(negedge clk);
      i_io_db  = db_val;
      i_rx_sop = 1'b1;
      @(negedge clk);
      i_rx_sop  = 1'b0;
      i_rx_vd   = 1'b1;
      i_rx_data = W_HEAD;
      @(negedge clk);
      i_rx_data = mtype;
      if (has_mode) begin
         @(negedge clk);
         i_rx_data = mmode;
      end
      if (has_chan) begin
         @(negedge clk);
         i_rx_data = hex_word(chan);
      end
      for (k = 0; k < n_data; k++) begin
         @(negedge clk);
         w = hex_word(dbytes[31-8*k -: 8]);
         // Bad digit goes into the last data word
         if (bad && k == n_data - 1) begin
            w[7:0] = "G";
         end
         i_rx_data = w;
      end
      @(negedge clk);
      i_rx_data = RX_END_WORD;
      @(negedge clk);
      i_rx_vd   = 1'b0;
      i_rx_data = '0;
      i_rx_eop  = 1'b1;
      @(negedge clk);
      i_rx_eop = 1'b0;
      @(negedge clk);
      check_pins();
      wait (done_cnt == test_num + 1);

      test_num++;
      if (err_cnt == err_start) begin
         $display("Test %0d %s: ok", test_num, name);
      end else begin
         fail_tests++;
         $display("Test %0d %s: failed, %0d errors", test_num, name, err_cnt - err_start);
      end
   endtask

   initial begin : stimulus
      logic [7:0]  chan;
      logic [31:0] dbytes;
      int          t;
      void'($urandom(54));
      i_rst_n    = 1'b0;
      i_rx_vd    = 1'b0;
      i_rx_data  = '0;
      i_rx_sop   = 1'b0;
      i_rx_eop   = 1'b0;
      i_io_db    = '0;
      st_mask    = '0;
      st_dir     = '0;
      st_data    = '0;
      pin_dir    = '0;
      pin_db     = '0;
      pin_bank   = '0;
      exp_eop_vd = 1'b0;
      err_cnt    = 0;
      fail_tests = 0;
      done_cnt   = 0;
      test_num   = 0;
      repeat (RST_CYCLES) @(negedge clk);
      i_rst_n = 1'b1;

      run_test("handshake", T_HS, 16'h0, 1'b0, 8'h00, 1'b0, 0, 32'h0, 1'b0);

      // Set alone, then a separate execute
      chan   = 8'($urandom);
      dbytes = $urandom;
      run_test("set", T_IO, M_SET, 1'b1, chan, 1'b1, 3, dbytes, 1'b0);
      chan = 8'($urandom);
      run_test("execute", T_IO, M_EXE, 1'b1, chan, 1'b1, 0, 32'h0, 1'b0);
      dbytes = $urandom;
      run_test("execute with data", T_IO, M_EXE, 1'b1, chan, 1'b1, 1, dbytes, 1'b0);

      for (t = 0; t < 6; t++) begin
         chan   = 8'($urandom);
         dbytes = $urandom;
         run_test("set and execute", T_IO, M_SEX, 1'b1, chan, 1'b1, 3, dbytes, 1'b0);
      end

      // Error cases leave settings and pins alone
      dbytes = $urandom;
      run_test("set bad hex", T_IO, M_SET, 1'b1, chan, 1'b1, 3, dbytes, 1'b1);
      dbytes = $urandom;
      run_test("set and execute bad hex", T_IO, M_SEX, 1'b1, chan, 1'b1, 3, dbytes, 1'b1);
      dbytes = $urandom;
      run_test("set short", T_IO, M_SET, 1'b1, chan, 1'b1, 2, dbytes, 1'b0);
      dbytes = $urandom;
      run_test("set and execute long", T_IO, M_SEX, 1'b1, chan, 1'b1, 4, dbytes, 1'b0);
      dbytes = $urandom;
      run_test("unknown mode", T_IO, "07", 1'b1, chan, 1'b1, 3, dbytes, 1'b0);

      chan = 8'($urandom);
      run_test("return", T_IO, M_RTN, 1'b1, chan, 1'b1, 0, 32'h0, 1'b0);
      run_test("handshake again", T_HS, 16'h0, 1'b0, 8'h00, 1'b0, 0, 32'h0, 1'b0);

      @(negedge clk);
      $display("Tests run %0d, tests failed %0d, check errors %0d",
               test_num, fail_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCH_CYCLES * CLK_PERIOD);
      $display("Run timed out, the DUT did not finish all replies in time");
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/io_ctrl.sv
// Judges each decoded message, keeps the IO settings and fills in the reply fields
`default_nettype none
`timescale 1ns/10ps

`include "pkt_decode_macros.svh"

module io_ctrl (
   input  wire                             clk,
   input  wire                             i_rst_n,
   input  wire  msg_pkg::msg_type_e        i_msg_type,
   input  wire  msg_pkg::msg_mode_e        i_msg_mode,
   input  wire  io_pkg::io_bank_t          i_ch_addr,
   input  wire  [`PKT_DATA_MAX_NBIT-1:0]   i_msg_data,
   input  wire  [3:0]                      i_data_cnt,
   input  wire                             i_msg_err,
   input  wire                             i_msg_eop,
   input  wire  io_pkg::io_word_t          i_io_db,
   output io_pkg::io_word_t                o_io_dir,
   output io_pkg::io_word_t                o_io_db,
   output io_pkg::io_bank_t                o_io_bank,
   output logic                            o_reply_start,
   output msg_pkg::msg_type_e              o_reply_type,
   output msg_pkg::msg_pf_e                o_reply_pf,
   output msg_pkg::msg_code_e              o_reply_code,
   output io_pkg::io_word_t                o_io_mask,
   output io_pkg::io_word_t                o_io_dir_st,
   output io_pkg::io_word_t                o_io_data_st
);

   import msg_pkg::*;
   import io_pkg::*;

   localparam logic [3:0] IO_CNT = 4'(`PKT_IO_DATA_NUM);

   logic       known;
   logic       do_set;
   logic       do_exe;
   msg_pf_e    pf;
   msg_code_e  code;
   io_word_t   new_mask;
   io_word_t   new_dir;
   io_word_t   new_data;
   io_word_t   msg_dir;
   io_word_t   msg_dat;

   //////////////////////////////
   // Code table
   //////////////////////////////

   always_comb begin
      known  = 1'b1;
      do_set = 1'b0;
      do_exe = 1'b0;
      pf     = PF_FAIL;
      code   = CODE_00;
      if (i_msg_type == TYPE_HANDSHAKE) begin
         pf   = PF_PASS;
         code = CODE_01;
      end else if (i_msg_type == TYPE_IOCTRL) begin
         case (i_msg_mode)
            MODE_SET, MODE_SEX: begin
               if (i_data_cnt != IO_CNT) begin
                  code = (i_msg_mode == MODE_SET) ? CODE_02 : CODE_22;
               end else if (i_msg_err) begin
                  code = (i_msg_mode == MODE_SET) ? CODE_03 : CODE_23;
               end else begin
                  pf     = PF_PASS;
                  code   = (i_msg_mode == MODE_SET) ? CODE_01 : CODE_21;
                  do_set = 1'b1;
                  do_exe = (i_msg_mode == MODE_SEX);
               end
            end
            MODE_EXE: begin
               if (i_data_cnt != 4'd0) begin
                  code = CODE_12;
               end else begin
                  pf     = PF_PASS;
                  code   = CODE_11;
                  do_exe = 1'b1;
               end
            end
            MODE_RTN: begin
               pf   = i_msg_err ? PF_FAIL : PF_PASS;
               code = i_msg_err ? CODE_23 : CODE_21;
            end
            default: ;
         endcase
      end else begin
         // Unknown type gets no reply
         known = 1'b0;
      end
   end

   //////////////////////////////
   // Per-bit merge
   //////////////////////////////

   // Data words arrive as mask, direction, data
   assign new_mask = i_msg_data[3*`PKT_IO_NBIT-1:2*`PKT_IO_NBIT];
   assign msg_dir  = i_msg_data[2*`PKT_IO_NBIT-1:`PKT_IO_NBIT];
   assign msg_dat  = i_msg_data[`PKT_IO_NBIT-1:0];

   // Masked bits keep the stored value, inputs sample the pins
   assign new_dir  = (new_mask & o_io_dir_st) | (~new_mask & msg_dir);
   assign new_data = (new_mask & o_io_data_st) |
                     (~new_mask & ((new_dir & msg_dat) | (~new_dir & i_io_db)));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_reply_start <= 1'b0;
         o_io_mask     <= '0;
         o_io_dir_st   <= '0;
         o_io_data_st  <= '0;
         o_io_dir      <= '0;
         o_io_db       <= '0;
         o_io_bank     <= '0;
      end else begin
         o_reply_start <= i_msg_eop & known;
         if (i_msg_eop && do_set) begin
            o_io_mask    <= new_mask;
            o_io_dir_st  <= new_dir;
            o_io_data_st <= new_data;
         end
         if (i_msg_eop && do_exe) begin
            o_io_dir  <= do_set ? new_dir : o_io_dir_st;
            o_io_db   <= do_set ? new_data : o_io_data_st;
            o_io_bank <= i_ch_addr;
         end
      end
   end

   // Reply fields, held until the next reply
   always_ff @(posedge clk) begin
      if (i_msg_eop && known) begin
         o_reply_type <= i_msg_type;
         o_reply_pf   <= pf;
         o_reply_code <= code;
      end
   end

   a_start_after_eop : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_reply_start |-> $past(i_msg_eop));

endmodule

`default_nettype wire

// File: hw/io_pkg.sv
// IO bank pin-word and bank-select types, imported by the decoder RTL
`default_nettype none

`include "pkt_decode_macros.svh"

package io_pkg;

   // One bank of pins, bit per pin
   typedef logic [`PKT_IO_NBIT-1:0]   io_word_t;

   // Bank select taken from the channel address
   typedef logic [`PKT_BANK_NBIT-1:0] io_bank_t;

endpackage

`default_nettype wire

// File: hw/msg_parser.sv
// Receive side of the decoder, walks message fields and hands them to io_ctrl
`default_nettype none
`timescale 1ns/10ps

`include "pkt_decode_macros.svh"

module msg_parser (
   input  wire                             clk,
   input  wire                             i_rst_n,
   input  wire                             i_rx_vd,
   input  wire  msg_pkg::msg_word_u        i_rx_data,
   input  wire                             i_rx_sop,
   input  wire                             i_rx_eop,
   output msg_pkg::msg_type_e              o_msg_type,
   output msg_pkg::msg_mode_e              o_msg_mode,
   output io_pkg::io_bank_t                o_ch_addr,
   output logic [`PKT_DATA_MAX_NBIT-1:0]   o_msg_data,
   output logic [3:0]                      o_data_cnt,
   output logic                            o_msg_err,
   output logic                            o_msg_eop
);

   import msg_pkg::*;

   rx_state_e   state;
   logic [7:0]  conv_byte;
   logic        conv_err;
   logic        is_end;

   always_comb begin
      conv_byte = hex_to_byte(i_rx_data, conv_err);
   end

   // End marker sits in the low character
   assign is_end = (i_rx_data.chr[0] == CHAR_LF) || (i_rx_data.chr[0] == CHAR_CR);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state      <= RX_IDLE;
         o_msg_eop  <= 1'b0;
         o_msg_err  <= 1'b0;
         o_data_cnt <= '0;
      end else begin
         o_msg_eop <= 1'b0;
         if (i_rx_sop) begin
            state      <= RX_HEAD;
            o_msg_type <= msg_type_e'('0);
            o_msg_mode <= msg_mode_e'('0);
            o_ch_addr  <= '0;
            o_msg_data <= '0;
            o_data_cnt <= '0;
            o_msg_err  <= 1'b0;
         end else if (i_rx_eop) begin
            // Only a message that got past the head field is reported
            o_msg_eop <= (state == RX_DATA) || (state == RX_END);
            state     <= RX_IDLE;
         end else if (i_rx_vd) begin
            case (state)
               RX_HEAD: begin
                  if (i_rx_data.code == MSG_HEAD) begin
                     state <= RX_TYPE;
                  end
               end
               RX_TYPE: begin
                  o_msg_type <= msg_type_e'(i_rx_data.code);
                  state      <= RX_MODE;
               end
               RX_MODE: begin
                  if (is_end) begin
                     state <= RX_END;
                  end else begin
                     o_msg_mode <= msg_mode_e'(i_rx_data.code);
                     state      <= RX_CHAN;
                  end
               end
               RX_CHAN: begin
                  if (is_end) begin
                     state <= RX_END;
                  end else begin
                     o_ch_addr <= conv_byte;
                     o_msg_err <= conv_err;
                     state     <= RX_DATA;
                  end
               end
               RX_DATA: begin
                  if (is_end) begin
                     state <= RX_END;
                  end else begin
                     o_msg_data <= {o_msg_data[`PKT_DATA_MAX_NBIT-`PKT_CHAR_NBIT-1:0],
                                    conv_byte};
                     o_data_cnt <= o_data_cnt + 4'd1;
                     o_msg_err  <= conv_err;
                  end
               end
               // Idle and end wait for sop or eop
               default: ;
            endcase
         end
      end
   end

   a_eop_single : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_msg_eop |=> !o_msg_eop);

endmodule

`default_nettype wire

// File: hw/msg_pkg.sv
// Message protocol types, field codes and hex conversion, imported by the decoder RTL
`default_nettype none

`include "pkt_decode_macros.svh"

package msg_pkg;

   // Same word read as a two-character code or as two characters
   typedef union packed {
      logic [`PKT_WORD_NBIT-1:0]         code;
      logic [1:0][`PKT_CHAR_NBIT-1:0]    chr;
   } msg_word_u;

   typedef enum logic [`PKT_WORD_NBIT-1:0] {
      TYPE_HANDSHAKE = "00",
      TYPE_IOCTRL    = "02"
   } msg_type_e;

   typedef enum logic [`PKT_WORD_NBIT-1:0] {
      MODE_SET  = "01",
      MODE_EXE  = "02",
      MODE_SEX  = "03",
      MODE_RTN  = "04"
   } msg_mode_e;

   typedef enum logic [`PKT_WORD_NBIT-1:0] {
      PF_PASS = "PA",
      PF_FAIL = "FA"
   } msg_pf_e;

   // First digit is the mode family, second the outcome
   typedef enum logic [`PKT_WORD_NBIT-1:0] {
      CODE_00 = "00",
      CODE_01 = "01",
      CODE_02 = "02",
      CODE_03 = "03",
      CODE_11 = "11",
      CODE_12 = "12",
      CODE_21 = "21",
      CODE_22 = "22",
      CODE_23 = "23"
   } msg_code_e;

   typedef enum logic [2:0] {
      RX_IDLE, RX_HEAD, RX_TYPE, RX_MODE, RX_CHAN, RX_DATA, RX_END
   } rx_state_e;

   typedef enum logic [2:0] {
      TX_IDLE, TX_HEAD, TX_TYPE, TX_PF, TX_CODE, TX_CHAN, TX_DATA, TX_END
   } tx_state_e;

   localparam logic [`PKT_WORD_NBIT-1:0] MSG_HEAD = "ST";
   localparam logic [`PKT_CHAR_NBIT-1:0] CHAR_LF  = 8'h0A;
   localparam logic [`PKT_CHAR_NBIT-1:0] CHAR_CR  = 8'h0D;
   localparam logic [`PKT_WORD_NBIT-1:0] MSG_END_MARK = {CHAR_LF, CHAR_CR};

   //////////////////////////////
   // Hex conversion
   //////////////////////////////

   function automatic logic [3:0] hex_to_nib(input logic [7:0] c, output logic bad);
      logic [7:0] d;
      bad = 1'b0;
      if (c >= "0" && c <= "9") begin
         d = c - "0";
      end else if (c >= "A" && c <= "F") begin
         d = c - "A" + 8'd10;
      end else if (c >= "a" && c <= "f") begin
         d = c - "a" + 8'd10;
      end else begin
         d = '0;
         bad = 1'b1;
      end
      return d[3:0];
   endfunction

   // High character is the high nibble
   function automatic logic [7:0] hex_to_byte(input msg_word_u w, output logic bad);
      logic bad_hi;
      logic bad_lo;
      logic [7:0] b;
      b[7:4] = hex_to_nib(w.chr[1], bad_hi);
      b[3:0] = hex_to_nib(w.chr[0], bad_lo);
      bad = bad_hi | bad_lo;
      return b;
   endfunction

   function automatic logic [7:0] nib_to_hex(input logic [3:0] n);
      return (n < 4'd10) ? ("0" + 8'(n)) : ("A" + 8'(n) - 8'd10);
   endfunction

   function automatic msg_word_u byte_to_hex(input logic [7:0] b);
      msg_word_u w;
      w.chr[1] = nib_to_hex(b[7:4]);
      w.chr[0] = nib_to_hex(b[3:0]);
      return w;
   endfunction

endpackage

`default_nettype wire

// File: hw/pkt_decode_macros.svh
// Width and count macros for the command decoder, included by the packages and RTL
`ifndef PKT_DECODE_MACROS_SVH
`define PKT_DECODE_MACROS_SVH

////////////////////////////////
// Link words
////////////////////////////////

// One host word carries two ASCII characters
`define PKT_WORD_NBIT      16
`define PKT_CHAR_NBIT      8

// Reply buffer holds 16 words
`define PKT_BUF_ADDR_NBIT  4

////////////////////////////////
// Message payload
////////////////////////////////

// Mask, direction and data bytes of one message
`define PKT_DATA_MAX_NBIT  24

////////////////////////////////
// IO bank
////////////////////////////////

`define PKT_IO_NBIT        8
`define PKT_BANK_NBIT      8

// Data words expected by an IO set message
`define PKT_IO_DATA_NUM    3

`endif

// File: hw/pkt_decode_top.sv
// Top level of the command decoder, connects parser, IO control and reply framer
`default_nettype none
`timescale 1ns/10ps

`include "pkt_decode_macros.svh"

module pkt_decode_top (
   input  wire                             clk,
   input  wire                             i_rst_n,
   input  wire                             i_rx_vd,
   input  wire  msg_pkg::msg_word_u        i_rx_data,
   input  wire                             i_rx_sop,
   input  wire                             i_rx_eop,
   input  wire  io_pkg::io_word_t          i_io_db,
   output wire  io_pkg::io_word_t          o_io_dir,
   output wire  io_pkg::io_word_t          o_io_db,
   output wire  io_pkg::io_bank_t          o_io_bank,
   output wire                             o_tx_vd,
   output wire  [`PKT_BUF_ADDR_NBIT:0]     o_tx_addr,
   output wire  msg_pkg::msg_word_u        o_tx_data,
   output wire                             o_tx_eop
);

   import msg_pkg::*;
   import io_pkg::*;

   // Parser to IO control
   msg_type_e                       msg_type;
   msg_mode_e                       msg_mode;
   io_bank_t                        ch_addr;
   logic [`PKT_DATA_MAX_NBIT-1:0]   msg_data;
   logic [3:0]                      data_cnt;
   logic                            msg_err;
   logic                            msg_eop;

   // IO control to framer
   logic                            reply_start;
   msg_type_e                       reply_type;
   msg_pf_e                         reply_pf;
   msg_code_e                       reply_code;
   io_word_t                        io_mask;
   io_word_t                        io_dir_st;
   io_word_t                        io_data_st;

   msg_parser u_parser (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rx_vd    (i_rx_vd),
      .i_rx_data  (i_rx_data),
      .i_rx_sop   (i_rx_sop),
      .i_rx_eop   (i_rx_eop),
      .o_msg_type (msg_type),
      .o_msg_mode (msg_mode),
      .o_ch_addr  (ch_addr),
      .o_msg_data (msg_data),
      .o_data_cnt (data_cnt),
      .o_msg_err  (msg_err),
      .o_msg_eop  (msg_eop)
   );

   io_ctrl u_ctrl (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_msg_type    (msg_type),
      .i_msg_mode    (msg_mode),
      .i_ch_addr     (ch_addr),
      .i_msg_data    (msg_data),
      .i_data_cnt    (data_cnt),
      .i_msg_err     (msg_err),
      .i_msg_eop     (msg_eop),
      .i_io_db       (i_io_db),
      .o_io_dir      (o_io_dir),
      .o_io_db       (o_io_db),
      .o_io_bank     (o_io_bank),
      .o_reply_start (reply_start),
      .o_reply_type  (reply_type),
      .o_reply_pf    (reply_pf),
      .o_reply_code  (reply_code),
      .o_io_mask     (io_mask),
      .o_io_dir_st   (io_dir_st),
      .o_io_data_st  (io_data_st)
   );

   reply_framer u_framer (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_reply_start (reply_start),
      .i_reply_type  (reply_type),
      .i_reply_pf    (reply_pf),
      .i_reply_code  (reply_code),
      .i_ch_addr     (ch_addr),
      .i_io_mask     (io_mask),
      .i_io_dir_st   (io_dir_st),
      .i_io_data_st  (io_data_st),
      .o_tx_vd       (o_tx_vd),
      .o_tx_addr     (o_tx_addr),
      .o_tx_data     (o_tx_data),
      .o_tx_eop      (o_tx_eop)
   );

endmodule

`default_nettype wire

// File: hw/reply_framer.sv
// Transmit side of the decoder, writes the reply frame into the host buffer
`default_nettype none
`timescale 1ns/10ps

`include "pkt_decode_macros.svh"

module reply_framer (
   input  wire                             clk,
   input  wire                             i_rst_n,
   input  wire                             i_reply_start,
   input  wire  msg_pkg::msg_type_e        i_reply_type,
   input  wire  msg_pkg::msg_pf_e          i_reply_pf,
   input  wire  msg_pkg::msg_code_e        i_reply_code,
   input  wire  io_pkg::io_bank_t          i_ch_addr,
   input  wire  io_pkg::io_word_t          i_io_mask,
   input  wire  io_pkg::io_word_t          i_io_dir_st,
   input  wire  io_pkg::io_word_t          i_io_data_st,
   output logic                            o_tx_vd,
   output logic [`PKT_BUF_ADDR_NBIT:0]     o_tx_addr,
   output msg_pkg::msg_word_u              o_tx_data,
   output logic                            o_tx_eop
);

   import msg_pkg::*;

   tx_state_e                          state;
   logic [`PKT_BUF_ADDR_NBIT-1:0]      buf_addr;
   logic [`PKT_DATA_MAX_NBIT-1:0]      data_sh;
   logic [$clog2(`PKT_IO_DATA_NUM)-1:0] data_left;
   logic                               mark_due;

   // Handshake replies go to bank 0, IO replies to bank 1
   assign o_tx_addr = {i_reply_type == TYPE_IOCTRL, buf_addr};

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= TX_IDLE;
         o_tx_vd  <= 1'b0;
         o_tx_eop <= 1'b0;
      end else begin
         o_tx_vd  <= 1'b0;
         o_tx_eop <= 1'b0;
         case (state)
            TX_IDLE: begin
               if (i_reply_start) begin
                  state <= TX_HEAD;
               end
            end
            TX_HEAD: begin
               o_tx_vd        <= 1'b1;
               o_tx_data.code <= MSG_HEAD;
               buf_addr       <= '0;
               state          <= TX_TYPE;
            end
            TX_TYPE: begin
               o_tx_vd        <= 1'b1;
               o_tx_data.code <= i_reply_type;
               buf_addr       <= buf_addr + 1'b1;
               state          <= TX_PF;
            end
            TX_PF: begin
               o_tx_vd        <= 1'b1;
               o_tx_data.code <= i_reply_pf;
               buf_addr       <= buf_addr + 1'b1;
               state          <= TX_CODE;
            end
            TX_CODE: begin
               o_tx_vd        <= 1'b1;
               o_tx_data.code <= i_reply_code;
               buf_addr       <= buf_addr + 1'b1;
               if (i_reply_type == TYPE_HANDSHAKE) begin
                  o_tx_eop <= 1'b1;
                  state    <= TX_IDLE;
               end else begin
                  state <= TX_CHAN;
               end
            end
            TX_CHAN: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= byte_to_hex(i_ch_addr);
               buf_addr  <= buf_addr + 1'b1;
               data_sh   <= {i_io_mask, i_io_dir_st, i_io_data_st};
               data_left <= $bits(data_left)'(`PKT_IO_DATA_NUM - 1);
               state     <= TX_DATA;
            end
            TX_DATA: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= byte_to_hex(data_sh[`PKT_DATA_MAX_NBIT-1 -: `PKT_CHAR_NBIT]);
               buf_addr  <= buf_addr + 1'b1;
               data_sh   <= data_sh << `PKT_CHAR_NBIT;
               data_left <= data_left - 1'b1;
               if (data_left == '0) begin
                  mark_due <= 1'b1;
                  state    <= TX_END;
               end
            end
            TX_END: begin
               // End marker first, then zeros to the end of the buffer
               if (buf_addr == '1) begin
                  o_tx_eop <= 1'b1;
                  state    <= TX_IDLE;
               end else begin
                  o_tx_vd        <= 1'b1;
                  o_tx_data.code <= mark_due ? MSG_END_MARK : '0;
                  buf_addr       <= buf_addr + 1'b1;
                  mark_due       <= 1'b0;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   a_addr_step : assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_tx_vd && !o_tx_eop) ##1 o_tx_vd |-> o_tx_addr == $past(o_tx_addr) + 1'b1);

endmodule

`default_nettype wire

// File: pkt_decode.f
+incdir+hw
hw/msg_pkg.sv
hw/io_pkg.sv
hw/msg_parser.sv
hw/io_ctrl.sv
hw/reply_framer.sv
hw/pkt_decode_top.sv
bench/tb_pkt_decode.sv
